// File: sim.f
common/ctrlPkg.sv
controller/ctrlSequencer.sv
controller/ctrlDecode.sv
controller/branchResolve.sv
rtl/mipsControl.sv
tests/ctrlChecker.sv
tests/tbMipsControl.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the MIPS control unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f sim.f --top-module tbMipsControl -Mdir obj_dir

./obj_dir/VtbMipsControl | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
  echo "run.sh: pass"
  exit 0
else
  echo "run.sh: fail"
  exit 1
fi

// File: tests/tbMipsControl.sv
`timescale 1ns/100ps
`default_nettype none

module tbMipsControl import ctrlPkg::*; ();

  typedef struct packed {
    logic [95:0]  name;      // all zero means random fields
    instrFields_t instr;
    logic         aluLsb;
    logic [3:0]   fetchWait;
    logic [3:0]   execWait;
    logic [3:0]   dataWait;
    logic [1:0]   haltIn;    // 1 fetch, 2 decode, 3 exec1
  } testRow_t;

  logic         clk = 1'b0;
  logic         rstN;
  instrFields_t instr;
  logic         aluLsb;
  logic         waitRequest;
  logic         execStall;
  logic         pcIsZero;
  logic         start;
  ctrlWord_t    ctrl;
  state_e       state;
  logic         active;
  testRow_t     curRow;
  testRow_t     rows [$];
  logic [31:0]  seed = 32'hd023c9f0;
  int           errCount;
  int           testCount;

  always #2 clk = ~clk;

  mipsControl uut (
    .clk, .rstN, .instr, .aluLsb, .waitRequest, .execStall, .pcIsZero, .start,
    .ctrl, .state, .active
  );

  ctrlChecker chk (
    .clk, .rstN, .ctrl, .state, .active, .pcIsZero, .waitRequest, .execStall, .start,
    .rowName   (curRow.name),
    .rowInstr  (curRow.instr),
    .rowLsb    (curRow.aluLsb),
    .fetchWait (curRow.fetchWait),
    .execWait  (curRow.execWait),
    .dataWait  (curRow.dataWait),
    .haltFlag  (curRow.haltIn != 2'd0),
    .errCount, .testCount
  );

  // plain LCG, numerical recipes constants
  function automatic logic [31:0] nextRand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  task automatic addRow(input logic [95:0] name, input logic [5:0] op, input logic [4:0] rt,
                        input logic [5:0] fn, input logic lsb, input int fw, input int ew,
                        input int dw, input int hlt);
    testRow_t r;
    r.name         = name;
    r.instr.opcode = opcode_e'(op);
    r.instr.rs     = 5'd3;
    r.instr.rt     = rt;
    r.instr.rest   = {10'd0, fn};
    r.aluLsb       = lsb;
    r.fetchWait    = 4'(fw);
    r.execWait     = 4'(ew);
    r.dataWait     = 4'(dw);
    r.haltIn       = 2'(hlt);
    rows.push_back(r);
  endtask

  task automatic buildTable();
    addRow("addu", opRType, 5'd2, fnAddu, 1'b0, 0, 0, 0, 0);
    addRow("and", opRType, 5'd2, fnAnd, 1'b0, 0, 0, 0, 0);
    addRow("or", opRType, 5'd2, fnOr, 1'b0, 0, 0, 0, 0);
    addRow("jr", opRType, 5'd0, fnJr, 1'b0, 0, 0, 0, 0);
    addRow("jalr", opRType, 5'd0, fnJalr, 1'b0, 0, 0, 0, 0);
    addRow("addiu", opAddiu, 5'd4, 6'd0, 1'b0, 0, 0, 0, 0);
    addRow("andi", opAndi, 5'd4, 6'd0, 1'b0, 0, 0, 0, 0);
    addRow("ori", opOri, 5'd4, 6'd0, 1'b0, 0, 0, 0, 0);
    addRow("slti", opSlti, 5'd4, 6'd0, 1'b1, 0, 0, 0, 0);
    addRow("sltiu", opSltiu, 5'd4, 6'd0, 1'b1, 0, 0, 0, 0);
    addRow("lw", opLw, 5'd5, 6'd0, 1'b0, 0, 0, 0, 0);
    addRow("sw", opSw, 5'd5, 6'd0, 1'b0, 0, 0, 0, 0);
    addRow("j", opJ, 5'd0, 6'd0, 1'b0, 0, 0, 0, 0);
    addRow("jal", opJal, 5'd0, 6'd0, 1'b0, 0, 0, 0, 0);
    addRow("unknownOp", 6'h3f, 5'd0, 6'd0, 1'b1, 0, 0, 0, 0);
    addRow("beqTaken", opBeq, 5'd6, 6'd0, 1'b1, 0, 0, 0, 0);
    addRow("beqNot", opBeq, 5'd6, 6'd0, 1'b0, 0, 0, 0, 0);
    addRow("bneTaken", opBne, 5'd6, 6'd0, 1'b0, 0, 0, 0, 0);
    addRow("bneNot", opBne, 5'd6, 6'd0, 1'b1, 0, 0, 0, 0);
    addRow("blezTaken", opBlez, 5'd0, 6'd0, 1'b1, 0, 0, 0, 0);
    addRow("blezNot", opBlez, 5'd0, 6'd0, 1'b0, 0, 0, 0, 0);
    addRow("bgtzTaken", opBgtz, 5'd0, 6'd0, 1'b0, 0, 0, 0, 0);
    addRow("bgtzNot", opBgtz, 5'd0, 6'd0, 1'b1, 0, 0, 0, 0);
    addRow("bltzTaken", opRegimm, riBltz, 6'd0, 1'b1, 0, 0, 0, 0);
    addRow("bltzNot", opRegimm, riBltz, 6'd0, 1'b0, 0, 0, 0, 0);
    addRow("bgezTaken", opRegimm, riBgez, 6'd0, 1'b0, 0, 0, 0, 0);
    addRow("bgezNot", opRegimm, riBgez, 6'd0, 1'b1, 0, 0, 0, 0);
    addRow("fetchWait", opRType, 5'd2, fnAddu, 1'b0, 2, 0, 0, 0);
    addRow("jalrStall", opRType, 5'd0, fnJalr, 1'b0, 0, 2, 0, 0);
    addRow("lwStall", opLw, 5'd5, 6'd0, 1'b0, 0, 1, 2, 0);
    addRow("swWait", opSw, 5'd5, 6'd0, 1'b0, 0, 0, 3, 0);
    addRow("jStall", opJ, 5'd0, 6'd0, 1'b0, 0, 1, 0, 0);
    addRow("haltFetch", opRType, 5'd2, fnAddu, 1'b0, 0, 0, 0, 1);
    addRow("haltDecode", opLw, 5'd5, 6'd0, 1'b0, 0, 0, 0, 2);
    addRow("haltExec", opRType, 5'd2, fnAddu, 1'b0, 0, 0, 0, 3);
    addRow('0, opAddiu, 5'd0, 6'd0, 1'b0, 0, 0, 0, 0);
    addRow('0, opLw, 5'd0, 6'd0, 1'b0, 0, 0, 0, 0);
    addRow('0, opBeq, 5'd0, 6'd0, 1'b1, 0, 0, 0, 0);
  endtask

  task automatic wakeIfHalted();
    if (state == stHalted) begin
      repeat (2) @(negedge clk);
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
    end
  endtask

  // entered on a falling edge in stFetch, left at the next stFetch or stHalted
  task automatic runRow(input int idx);
    testRow_t    r;
    logic [31:0] rnd;
    int          fCnt;
    int          eCnt;
    int          dCnt;
    logic        haltDone;
    r = rows[idx];
    if (r.name == '0) begin
      rnd = nextRand();
      r.name = {"rnd", 8'(48 + idx / 10), 8'(48 + idx % 10)};
      r.instr.rs = rnd[4:0];
      if (r.instr.opcode != opRegimm) r.instr.rt = rnd[9:5]; // rt picks the REGIMM branch
      if (r.instr.opcode == opRType) r.instr.rest[15:6] = rnd[31:22];
      else r.instr.rest = rnd[31:16];
    end
    curRow = r;
    instr = r.instr;
    aluLsb = r.aluLsb;
    fCnt = 0;
    eCnt = 0;
    dCnt = 0;
    haltDone = 1'b0;
    do begin
      waitRequest = 1'b0;
      execStall = 1'b0;
      pcIsZero = 1'b0;
      if ((state == stFetch || state == stStall) && fCnt < r.fetchWait) begin
        waitRequest = 1'b1;
        fCnt++;
      end else if (state == stExec1 && eCnt < r.execWait) begin
        execStall = 1'b1;
        eCnt++;
      end else if (state == stExec2 && dCnt < r.dataWait) begin
        waitRequest = 1'b1; // data side wait
        dCnt++;
      end
      if (!haltDone && ((r.haltIn == 2'd1 && state == stFetch) ||
          (r.haltIn == 2'd2 && state == stDecode) || (r.haltIn == 2'd3 && state == stExec1))) begin
        pcIsZero = 1'b1;
        haltDone = 1'b1;
      end
      @(negedge clk);
    end while (state != stFetch && state != stHalted);
    waitRequest = 1'b0;
    execStall = 1'b0;
    pcIsZero = 1'b0;
  endtask

  initial begin
    rstN = 1'b0;
    instr = '0;
    aluLsb = 1'b0;
    waitRequest = 1'b0;
    execStall = 1'b0;
    pcIsZero = 1'b0;
    start = 1'b0;
    curRow = '0;
    buildTable();
    repeat (4) @(negedge clk);
    rstN = 1'b1;
    for (int i = 0; i < rows.size(); i++) begin
      wakeIfHalted();
      runRow(i);
    end
    @(negedge clk); // checker closes the last test
    $display("tests %0d of %0d, errors %0d", testCount, rows.size(), errCount);
    if (errCount == 0 && testCount == rows.size()) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    int limit;
    #1;
    limit = rows.size() * 24 + 50;
    repeat (limit) @(posedge clk);
    $display("timeout: the tests did not finish within %0d cycles", limit);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/ctrlChecker.sv
`timescale 1ns/100ps
`default_nettype none

module ctrlChecker import ctrlPkg::*; (
  input  logic         clk,
  input  logic         rstN,
  input  ctrlWord_t    ctrl,
  input  state_e       state,
  input  logic         active,
  input  logic         pcIsZero,
  input  logic         waitRequest,
  input  logic         execStall,
  input  logic         start,
  input  logic [95:0]  rowName,
  input  instrFields_t rowInstr,
  input  logic         rowLsb,
  input  logic [3:0]   fetchWait,
  input  logic [3:0]   execWait,
  input  logic [3:0]   dataWait,
  input  logic         haltFlag,
  output int           errCount,
  output int           testCount
);

  logic [95:0]  name = "reset";
  instrFields_t ins;
  logic         lsb;
  logic         hf;
  logic         open = 1'b0;
  logic         pending = 1'b0;  // expected branch-delay flag
  logic         haltDue = 1'b0;
  logic         fromReset = 1'b0;
  state_e       expState = stHalted;
  int           fw;
  int           ew;
  int           dw;
  int           errs = 0;
  int           tests = 0;
  int           errAtOpen;
  int           seen [16];       // 0..7 per state, then regWr, memWr, memRd, isJump, link

  assign errCount  = errs;
  assign testCount = tests;

  function automatic int execLen(instrFields_t i);
    case (i.opcode)
      opRType: return (i.rest[5:0] inside {fnAddu, fnAnd, fnOr, fnJalr}) ? 2 : 1;
      opAddiu, opSlti, opSltiu, opAndi, opOri, opSw: return 2;
      opLw: return 3;
      default: return 1;
    endcase
  endfunction

  function automatic logic isTaken(instrFields_t i, logic l);
    case (i.opcode)
      opJ, opJal: return 1'b1;
      opRType: return (i.rest[5:0] == fnJr) || (i.rest[5:0] == fnJalr);
      opBeq, opBlez: return l;
      opBne, opBgtz: return !l;
      opRegimm: return (i.rt == riBltz) ? l : (i.rt == riBgez) ? !l : 1'b0;
      default: return 1'b0;
    endcase
  endfunction

  // reference model of the state sequence, kept apart from the DUT
  function automatic state_e nextExp(state_e s, instrFields_t i);
    if (s != stHalted && pcIsZero) return stHalted;
    case (s)
      stFetch, stStall: return waitRequest ? stStall : stDecode;
      stDecode: return stExec1;
      stExec1: return execStall ? stExec1 : (execLen(i) >= 2) ? stExec2 : stFetch;
      stExec2: return waitRequest ? stExec2 : (execLen(i) == 3) ? stExec3 : stFetch;
      stExec3: return stFetch;
      stHalted: return start ? stFetch : stHalted;
      default: return stHalted;
    endcase
  endfunction

  task automatic compare(input string what, input int expVal, input int actVal);
    if (expVal != actVal) begin
      errs++;
      $display("ERR %0s %0s expected %0d actual %0d", name, what, expVal, actVal);
    end
  endtask

  task automatic closeTest();
    int   len;
    logic isJalr;
    logic isAlu;
    len = execLen(ins);
    isJalr = (ins.opcode == opRType) && (ins.rest[5:0] == fnJalr);
    isAlu = (len == 2) && !isJalr && (ins.opcode != opSw);
    tests++;
    if (state == stHalted && !hf) begin
      errs++;
      $display("%0s: unit halted although pcIsZero stayed low", name);
    end else if (state != stHalted && hf) begin
      errs++;
      $display("%0s: unit kept running after pcIsZero", name);
    end else if (state != stHalted) begin
      compare("stall cycles", fw, seen[stStall]);
      compare("exec1 cycles", 1 + ew, seen[stExec1]);
      compare("exec2 cycles", (len >= 2) ? 1 + dw : 0, seen[stExec2]);
      compare("exec3 cycles", (len == 3) ? 1 : 0, seen[stExec3]);
      compare("regWrite", isAlu ? 1 + dw : isJalr ? 1 + ew : (len == 3) ? 1 : 0, seen[8]);
      compare("memWrite", (ins.opcode == opSw) ? 1 + dw : 0, seen[9]);
      compare("memRead", 1 + fw + ((len == 3) ? 1 + dw : 0), seen[10]);
      compare("isJump", (ins.opcode inside {opJ, opJal}) ? 1 + ew : 0, seen[11]);
      compare("link", (ins.opcode == opJal) ? 1 + ew : 0, seen[12]);
      pending = isTaken(ins, lsb);
    end
    $display("test %0s done, %0d errors", name, errs - errAtOpen);
  endtask

  always @(posedge clk) begin
    if (!rstN) begin
      fromReset = 1'b1;
      expState = stHalted;
    end else begin
      if (fromReset) compare("state after reset", int'(stHalted), int'(state));
      fromReset = 1'b0;
      if (haltDue) compare("state after pcIsZero", int'(stHalted), int'(state));
      haltDue = pcIsZero && (state != stHalted);
      compare("state", int'(expState), int'(state));
      if (open && (state == stFetch || state == stHalted)) begin
        closeTest();
        open = 1'b0;
      end
      if (state == stFetch) begin
        open = 1'b1;
        name = rowName;
        ins = rowInstr;
        lsb = rowLsb;
        hf = haltFlag;
        fw = int'(fetchWait);
        ew = int'(execWait);
        dw = int'(dataWait);
        errAtOpen = errs;
        foreach (seen[k]) seen[k] = 0;
      end
      compare("active", expState != stHalted, active);
      compare("pcWrite", expState == stFetch, ctrl.pcWrite);
      compare("irWrite", expState == stDecode, ctrl.irWrite);
      if (state == stHalted) begin
        compare("strobes while halted", 0, {ctrl.memRead, ctrl.memWrite, ctrl.regWrite,
                                            ctrl.isJump, ctrl.link, ctrl.pcSrc});
      end
      if (state == stFetch) begin
        compare("pcSrc", pending, ctrl.pcSrc);
        if (!pending) compare("fetch aluSrcB", int'(srcBFour), int'(ctrl.aluSrcB)); // pc + 4
        pending = 1'b0; // consumed by this fetch
      end
      if (state == stDecode) compare("decode aluSrcB", int'(srcBTarget), int'(ctrl.aluSrcB));
      if (open) begin
        seen[state]++;
        seen[8] += ctrl.regWrite;
        seen[9] += ctrl.memWrite;
        seen[10] += ctrl.memRead;
        seen[11] += ctrl.isJump;
        seen[12] += ctrl.link;
      end
      expState = nextExp(expState, ins);
    end
  end

endmodule

`default_nettype wire

// File: rtl/mipsControl.sv
`timescale 1ns/100ps
`default_nettype none

module mipsControl import ctrlPkg::*; (
  input  logic         clk,
  input  logic         rstN,
  input  instrFields_t instr,
  input  logic         aluLsb,
  input  logic         waitRequest,
  input  logic         execStall,
  input  logic         pcIsZero,
  input  logic         start,
  output ctrlWord_t    ctrl,
  output state_e       state,
  output logic         active
);

  logic        needMore;
  logic        lastExec;
  logic        fetchRead;
  logic        dataRead;
  logic        branchPending;
  branchKind_e branchKind;

  ctrlSequencer uSeq (
    .clk, .rstN, .needMore, .waitRequest, .execStall, .pcIsZero, .start,
    .state, .active,
    .pcWrite   (ctrl.pcWrite),
    .irWrite   (ctrl.irWrite),
    .fetchRead
  );

  ctrlDecode uDec (
    .state, .instr, .branchPending,
    .iorD      (ctrl.iorD),
    .aluSrcA   (ctrl.aluSrcA),
    .aluSel    (ctrl.aluSel),
    .extSel    (ctrl.extSel),
    .regDst    (ctrl.regDst),
    .memToReg  (ctrl.memToReg),
    .regWrite  (ctrl.regWrite),
    .dataRead,
    .memWrite  (ctrl.memWrite),
    .pcSrc     (ctrl.pcSrc),
    .isJump    (ctrl.isJump),
    .link      (ctrl.link),
    .needMore, .lastExec,
    .aluSrcB   (ctrl.aluSrcB),
    .aluOp     (ctrl.aluOp),
    .branchKind
  );

  branchResolve uBr (
    .clk, .rstN, .branchKind, .aluLsb, .lastExec,
    .pcWrite   (ctrl.pcWrite),
    .branchPending
  );

  assign ctrl.memRead = fetchRead | dataRead; // instruction fetch or LW data

endmodule

`default_nettype wire

// File: controller/branchResolve.sv
`timescale 1ns/100ps
`default_nettype none

module branchResolve import ctrlPkg::*; (
  input  logic        clk,
  input  logic        rstN,
  input  branchKind_e branchKind,
  input  logic        aluLsb,
  input  logic        lastExec,
  input  logic        pcWrite,
  output logic        branchPending
);

  logic taken;

  always_comb begin
    case (branchKind)
      brAlways:  taken = 1'b1;
      brIfSet:   taken = aluLsb;
      brIfClear: taken = !aluLsb;
      default:   taken = 1'b0;
    endcase
  end

  // loaded at the end of every instruction, consumed by the next fetch
  always_ff @(posedge clk) begin
    if (!rstN) begin
      branchPending <= 1'b0;
    end else if (lastExec) begin
      branchPending <= taken;
    end else if (pcWrite) begin
      branchPending <= 1'b0; // target taken by this fetch
    end
  end

  noPendingAfterReset: assert property (
    @(posedge clk) !rstN |=> !branchPending
  ) else $error("branch flag set right after reset");

endmodule

`default_nettype wire

// File: controller/ctrlDecode.sv
`timescale 1ns/100ps
`default_nettype none

module ctrlDecode import ctrlPkg::*; (
  input  state_e       state,
  input  instrFields_t instr,
  input  logic         branchPending,
  output logic         iorD,
  output logic         aluSrcA,
  output logic         aluSel,
  output logic         extSel,
  output logic         regDst,
  output logic         memToReg,
  output logic         regWrite,
  output logic         dataRead,
  output logic         memWrite,
  output logic         pcSrc,
  output logic         isJump,
  output logic         link,
  output logic         needMore,
  output logic         lastExec,
  output aluSrcB_e     aluSrcB,
  output aluOp_e       aluOp,
  output branchKind_e  branchKind
);

  funct_e  funct;
  regimm_e rtCode;
  logic    isExec;

  assign funct  = funct_e'(instr.rest[5:0]);
  assign rtCode = regimm_e'(instr.rt);
  assign isExec = (state == stExec1) || (state == stExec2) || (state == stExec3);

  always_comb begin
    iorD       = 1'b0;
    aluSrcA    = 1'b0;
    aluSrcB    = srcBReg;
    aluOp      = aluAdd;
    aluSel     = 1'b0;
    extSel     = 1'b0;
    regDst     = 1'b0;
    memToReg   = 1'b0;
    regWrite   = 1'b0;
    dataRead   = 1'b0;
    memWrite   = 1'b0;
    pcSrc      = 1'b0;
    isJump     = 1'b0;
    link       = 1'b0;
    needMore   = 1'b0;
    lastExec   = 1'b0;
    branchKind = brNone;

    if (state == stFetch) begin
      if (branchPending) begin
        pcSrc = 1'b1; // target already sits in the ALU out register
      end else begin
        aluSrcB = srcBFour; // pc + 4
      end
    end else if (state == stDecode) begin
      aluSrcB = srcBTarget;
      if (instr.opcode == opJ || instr.opcode == opJal) begin
        extSel = 1'b1;
        aluOp  = aluPassB; // jump target straight through
      end else begin
        aluOp  = aluAddTarget; // speculative branch target
      end
    end else if (isExec) begin
      case (instr.opcode)
        opRType: begin
          if (funct == fnJr) begin
            aluSrcA    = 1'b1;
            aluOp      = aluPassA;
            branchKind = brAlways;
            lastExec   = 1'b1;
          end else if (funct == fnJalr) begin
            if (state == stExec1) begin
              aluSrcB  = srcBFour; // return address into rd
              regDst   = 1'b1;
              regWrite = 1'b1;
              needMore = 1'b1;
            end else begin
              aluSrcA    = 1'b1;
              aluOp      = aluPassA;
              aluSel     = 1'b1;
              branchKind = brAlways;
              lastExec   = 1'b1;
            end
          end else if (funct == fnAddu || funct == fnAnd || funct == fnOr) begin
            aluSrcA = 1'b1;
            aluOp   = aluFunct;
            if (state == stExec1) begin
              needMore = 1'b1;
            end else begin
              aluSel   = 1'b1;
              regDst   = 1'b1;
              regWrite = 1'b1;
              lastExec = 1'b1;
            end
          end else begin
            lastExec = 1'b1; // unknown funct, nothing happens
          end
        end
        opAddiu, opSlti, opSltiu, opAndi, opOri: begin
          aluSrcA = 1'b1;
          aluSrcB = srcBImm;
          case (instr.opcode)
            opSlti:  aluOp = aluSlt;
            opSltiu: aluOp = aluSltu;
            opAndi:  aluOp = aluAnd;
            opOri:   aluOp = aluOr;
            default: aluOp = aluAdd;
          endcase
          extSel = (instr.opcode == opAndi) || (instr.opcode == opOri); // logic ops zero-extend
          if (state == stExec1) begin
            needMore = 1'b1;
          end else begin
            aluSel   = 1'b1;
            regWrite = 1'b1; // rt
            lastExec = 1'b1;
          end
        end
        opLw, opSw: begin
          if (state == stExec1) begin
            aluSrcA  = 1'b1;
            aluSrcB  = srcBImm; // base + offset
            needMore = 1'b1;
          end else if (state == stExec2) begin
            iorD   = 1'b1;
            aluSel = 1'b1;
            if (instr.opcode == opLw) begin
              dataRead = 1'b1;
              needMore = 1'b1;
            end else begin
              memWrite = 1'b1;
              lastExec = 1'b1;
            end
          end else begin
            memToReg = 1'b1;
            regWrite = 1'b1;
            lastExec = 1'b1;
          end
        end
        opBeq, opBne: begin
          aluSrcA    = 1'b1;
          aluOp      = aluEq;
          aluSel     = 1'b1;
          branchKind = (instr.opcode == opBeq) ? brIfSet : brIfClear;
          lastExec   = 1'b1;
        end
        opBlez, opBgtz: begin
          aluSrcA    = 1'b1;
          aluOp      = aluLeZero;
          aluSel     = 1'b1;
          branchKind = (instr.opcode == opBlez) ? brIfSet : brIfClear;
          lastExec   = 1'b1;
        end
        opRegimm: begin
          aluSrcA  = 1'b1;
          aluOp    = aluLtZero;
          aluSel   = 1'b1;
          lastExec = 1'b1;
          if (rtCode == riBltz) begin
            branchKind = brIfSet;
          end else if (rtCode == riBgez) begin
            branchKind = brIfClear;
          end
        end
        opJ: begin
          isJump     = 1'b1;
          branchKind = brAlways;
          lastExec   = 1'b1;
        end
        opJal: begin
          aluSrcB    = srcBFour; // link value pc + 4
          isJump     = 1'b1;
          link       = 1'b1;
          branchKind = brAlways;
          lastExec   = 1'b1;
        end
        default: begin
          lastExec = 1'b1;
        end
      endcase
    end
  end

  always_comb begin
    assert (!(regWrite && memWrite)) else $error("regWrite and memWrite together");
  end

endmodule

`default_nettype wire

// File: controller/ctrlSequencer.sv
`timescale 1ns/100ps
`default_nettype none

module ctrlSequencer import ctrlPkg::*; (
  input  logic   clk,
  input  logic   rstN,
  input  logic   needMore,
  input  logic   waitRequest,
  input  logic   execStall,
  input  logic   pcIsZero,
  input  logic   start,
  output state_e state,
  output logic   active,
  output logic   pcWrite,
  output logic   irWrite,
  output logic   fetchRead
);

  state_e nextState;

  always_comb begin
    nextState = state;
    if (state != stHalted && pcIsZero) begin
      nextState = stHalted; // pc hit zero, stop after this cycle
    end else begin
      case (state)
        stFetch: begin
          nextState = waitRequest ? stStall : stDecode;
        end
        stStall: begin
          nextState = waitRequest ? stStall : stDecode;
        end
        stDecode: begin
          nextState = stExec1;
        end
        stExec1: begin
          if (execStall) begin
            nextState = stExec1;
          end else if (needMore) begin
            nextState = stExec2;
          end else begin
            nextState = stFetch;
          end
        end
        stExec2: begin
          // data access waits here
          if (waitRequest) begin
            nextState = stExec2;
          end else if (needMore) begin
            nextState = stExec3;
          end else begin
            nextState = stFetch;
          end
        end
        stExec3: begin
          nextState = stFetch;
        end
        stHalted: begin
          nextState = start ? stFetch : stHalted;
        end
        default: begin
          nextState = stHalted;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= stHalted;
    end else begin
      state <= nextState;
    end
  end

  assign active    = (state != stHalted);
  assign pcWrite   = (state == stFetch);
  assign irWrite   = (state == stDecode);
  assign fetchRead = (state == stFetch) || (state == stStall); // held across fetch wait

  // only the start strobe wakes a halted unit
  haltNeedsStart: assert property (
    @(posedge clk) disable iff (!rstN)
    (state == stHalted && !start) |=> (state == stHalted)
  ) else $error("left stHalted without start");

endmodule

`default_nettype wire

// File: common/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

  // primary opcode field, bits 31:26
  typedef enum logic [5:0] {
    opRType  = 6'b000000,
    opRegimm = 6'b000001,
    opJ      = 6'b000010,
    opJal    = 6'b000011,
    opBeq    = 6'b000100,
    opBne    = 6'b000101,
    opBlez   = 6'b000110,
    opBgtz   = 6'b000111,
    opAddiu  = 6'b001001,
    opSlti   = 6'b001010,
    opSltiu  = 6'b001011,
    opAndi   = 6'b001100,
    opOri    = 6'b001101,
    opLw     = 6'b100011,
    opSw     = 6'b101011
  } opcode_e;

  // R-type function field, bits 5:0
  typedef enum logic [5:0] {
    fnJr   = 6'b001000,
    fnJalr = 6'b001001,
    fnAddu = 6'b100001,
    fnAnd  = 6'b100100,
    fnOr   = 6'b100101
  } funct_e;

  // rt field under REGIMM
  typedef enum logic [4:0] {
    riBltz = 5'b00000,
    riBgez = 5'b00001
  } regimm_e;

  typedef enum logic [2:0] {
    stFetch  = 3'b000,
    stDecode = 3'b001,
    stExec1  = 3'b010,
    stExec2  = 3'b011,
    stExec3  = 3'b100,
    stHalted = 3'b101,
    stStall  = 3'b110
  } state_e;

  // compare ops leave their result in the ALU lsb
  typedef enum logic [4:0] {
    aluAnd       = 5'b00000,
    aluOr        = 5'b00001,
    aluAdd       = 5'b00010,
    aluSlt       = 5'b00111,
    aluLtZero    = 5'b01000, // rs < 0
    aluSltu      = 5'b01001,
    aluEq        = 5'b01010, // rs == rt
    aluPassB     = 5'b01011,
    aluLeZero    = 5'b01100, // rs <= 0
    aluAddTarget = 5'b01101, // pc + branch offset
    aluPassA     = 5'b01110,
    aluFunct     = 5'b01111  // op taken from the funct field
  } aluOp_e;

  typedef enum logic [1:0] {
    srcBReg    = 2'b00,
    srcBFour   = 2'b01,
    srcBImm    = 2'b10,
    srcBTarget = 2'b11
  } aluSrcB_e;

  // how the branch-delay flag is loaded at the end of an instruction
  typedef enum logic [1:0] {
    brNone    = 2'b00,
    brAlways  = 2'b01,
    brIfSet   = 2'b10, // taken when ALU lsb is 1
    brIfClear = 2'b11  // taken when ALU lsb is 0
  } branchKind_e;

  // one control word per cycle for the datapath
  typedef struct packed {
    logic        iorD;
    logic        aluSrcA;   // 0 pc, 1 rs
    aluSrcB_e    aluSrcB;
    aluOp_e      aluOp;
    logic        aluSel;    // take the registered ALU result
    logic        extSel;    // zero extension, jump target form in J/JAL
    logic        regDst;    // 1 writes rd, 0 writes rt
    logic        memToReg;  // 1 writes load data
    logic        regWrite;
    logic        memRead;
    logic        memWrite;
    logic        pcWrite;
    logic        pcSrc;     // 1 loads the branch target
    logic        irWrite;
    logic        isJump;
    logic        link;
  } ctrlWord_t;

  typedef struct packed {
    opcode_e     opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] rest;      // rd, shamt, funct or the immediate
  } instrFields_t;

endpackage

`default_nettype wire
